// File: logic/intc_pkg.sv
/* Shared widths and register map of the interrupt controller.
   Vector numbers are 5 bits, so at most 32 sources can exist */
package intc_pkg;

    // Upper limit on the number of interrupt sources
    localparam int MAX_SOURCES = 32;

    // Vector number, i.e. source index
    localparam int VEC_ID_W = $clog2(MAX_SOURCES);
    typedef logic [VEC_ID_W-1:0] vec_id_t;

    // Wishbone classic port
    localparam int WB_DATA_W = 32;
    localparam int WB_ADDR_W = 2;
    typedef logic [WB_DATA_W-1:0] wb_data_t;
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;   // Word address

    // Register word addresses, address 3 is unused
    localparam wb_addr_t ADDR_MASK   = 2'd0;   // RW, 1 = source enabled
    localparam wb_addr_t ADDR_VECTOR = 2'd1;   // RO, pops one vector per read
    localparam wb_addr_t ADDR_STATUS = 2'd2;   // RO, pending bits

    // VECTOR read layout
    // Bit 31 flags a popped vector
    // Low bits carry the vec_id_t
    localparam int VECTOR_VALID_BIT = 31;

endpackage

// File: logic/int_capture.sv
`timescale 1ns/1ps
/* Async level inputs, only rising edges pend. A source must fall and rise again to pend
   again; an edge on a bit that is already pending merges into it */
module int_capture #(
    parameter int VEC_W = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [VEC_W-1:0] int_in,        // Raw sources, asynchronous
    input  logic [VEC_W-1:0] mask,          // 1 = enabled
    input  logic [VEC_W-1:0] claim_onehot,  // Bit taken by the dispatcher
    output logic [VEC_W-1:0] pending
);

    logic [VEC_W-1:0] sync_1;       // First synchronizer flop
    logic [VEC_W-1:0] sync_2;       // Second synchronizer flop
    logic [VEC_W-1:0] sync_d;       // Last synchronized level
    logic [VEC_W-1:0] rise;
    logic [VEC_W-1:0] pending_nxt;

    // Two flops against metastability, plus the edge register
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_1 <= '0;
            sync_2 <= '0;
            sync_d <= '0;
        end else begin
            sync_1 <= int_in;
            sync_2 <= sync_1;
            sync_d <= sync_2;
        end
    end

    // Low to high on the synchronized level
    assign rise = sync_2 & ~sync_d;

    // Sticky pending
    // Claimed bits drop
    // New edges only count on idle bits
    // A mask bit at 0 forces the bit clear
    always_comb begin
        pending_nxt = pending & ~claim_onehot;   // Claim wins over hold
        pending_nxt = pending_nxt | (rise & ~pending);
        pending_nxt = pending_nxt & mask;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            pending <= pending_nxt;
        end
    end

endmodule

// File: logic/int_dispatch.sv
`timescale 1ns/1ps
/* Purely combinational, claims at most one source per cycle. Lowest index has highest
   priority; nothing is claimed while the FIFO is full */
module int_dispatch #(
    parameter int VEC_W = 16
) (
    input  logic                 [VEC_W-1:0] pending,
    input  logic                             full,          // FIFO back-pressure
    output logic                 [VEC_W-1:0] claim_onehot,  // Clear strobe to capture
    output logic                             push,
    output intc_pkg::vec_id_t                push_id
);

    logic              [VEC_W-1:0] lowest;     // One-hot of the lowest set bit
    intc_pkg::vec_id_t             sel_id;     // Index of that bit
    logic                          any_pend;

    assign any_pend = |pending;

    // Priority encoder
    // Walk from the top down so the lowest index is the last one kept
    always_comb begin
        lowest = '0;
        sel_id = '0;
        for (int i = VEC_W - 1; i >= 0; i--) begin
            if (pending[i]) begin
                lowest = '0;
                lowest[i] = 1'b1;
                sel_id = intc_pkg::vec_id_t'(i);
            end
        end
    end

    // Claim and push together, so entry and clear share one edge
    assign push         = any_pend & ~full;
    assign push_id      = sel_id;
    assign claim_onehot = push ? lowest : '0;   // Held off under back-pressure

endmodule

// File: logic/vector_fifo.sv
`timescale 1ns/1ps
/* FIFO_DEPTH must be a power of two and at least 2. Push while full and pop while
   empty are dropped; the head word is valid whenever empty is low */
module vector_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          push,
    input  intc_pkg::vec_id_t             push_id,
    input  logic                          pop,
    output intc_pkg::vec_id_t             pop_id,   // Head of queue
    output logic                          empty,
    output logic                          full,
    output logic [$clog2(FIFO_DEPTH):0]   count     // Occupancy, 0..FIFO_DEPTH
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    intc_pkg::vec_id_t mem [FIFO_DEPTH];   // Vector storage, no reset
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              do_push;
    logic              do_pop;

    // Guarded strobes
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // Status from the count only
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(FIFO_DEPTH));

    assign pop_id = mem[rd_ptr];   // First word fall-through

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_id;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

// File: logic/wb_intc_regs.sv
`timescale 1ns/1ps
/* Wishbone classic slave, ack one cycle after the request, no wait states, no errors.
   Master holds the request until ack; a VECTOR read pops the FIFO on its ack cycle */
module wb_intc_regs #(
    parameter int VEC_W = 16
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  intc_pkg::wb_addr_t               wb_adr,
    input  intc_pkg::wb_data_t               wb_dat_i,
    output intc_pkg::wb_data_t               wb_dat_o,
    output logic                             wb_ack,
    input  logic                 [VEC_W-1:0] pending,
    input  intc_pkg::vec_id_t                pop_id,   // FIFO head
    input  logic                             empty,
    output logic                 [VEC_W-1:0] mask,     // 1 = source enabled
    output logic                             pop,
    output logic                             irq
);

    logic               req;        // Live cycle addressed to us
    logic               acc;        // Access completes this cycle
    intc_pkg::wb_data_t vec_word;   // VECTOR read value
    intc_pkg::wb_data_t rd_data;

    assign req = wb_cyc & wb_stb;
    assign acc = req & wb_ack;

    // Single-cycle ack, never back to back on a held request
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req & ~wb_ack;
        end
    end

    // MASK write lands on the ack cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mask <= '0;
        end else if (acc && wb_we && wb_adr == intc_pkg::ADDR_MASK) begin
            mask <= wb_dat_i[VEC_W-1:0];   // Upper data bits ignored
        end
    end

    // Valid flag plus vector number, all zero when nothing is queued
    always_comb begin
        vec_word = '0;
        if (!empty) begin
            vec_word[intc_pkg::VECTOR_VALID_BIT] = 1'b1;
            vec_word[intc_pkg::VEC_ID_W-1:0]     = pop_id;
        end
    end

    // Read mux
    always_comb begin
        case (wb_adr)
            intc_pkg::ADDR_MASK:   rd_data = intc_pkg::wb_data_t'(mask);
            intc_pkg::ADDR_VECTOR: rd_data = vec_word;
            intc_pkg::ADDR_STATUS: rd_data = intc_pkg::wb_data_t'(pending);   // Zero-extended
            default:               rd_data = '0;   // Address 3
        endcase
    end

    // Valid while wb_ack is high, same head word that gets popped
    assign wb_dat_o = rd_data;

    // One pop per VECTOR read, only when there is something to pop
    assign pop = acc & ~wb_we & (wb_adr == intc_pkg::ADDR_VECTOR) & ~empty;

    // irq trails not-empty by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            irq <= 1'b0;
        end else begin
            irq <= ~empty;
        end
    end

endmodule

// File: logic/intc_top.sv
`timescale 1ns/1ps
/* VEC_W from 1 to 32, FIFO_DEPTH a power of two. Edge to irq takes 5 cycles with an
   empty FIFO and the source enabled; mask resets to all off */
module intc_top #(
    parameter int VEC_W      = 16,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                 [VEC_W-1:0] int_in,   // Async interrupt sources
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  intc_pkg::wb_addr_t               wb_adr,
    input  intc_pkg::wb_data_t               wb_dat_i,
    output intc_pkg::wb_data_t               wb_dat_o,
    output logic                             wb_ack,
    output logic                             irq
);

    logic              [VEC_W-1:0] pending;
    logic              [VEC_W-1:0] claim_onehot;
    logic              [VEC_W-1:0] mask;
    logic                          push;
    intc_pkg::vec_id_t             push_id;
    logic                          pop;
    intc_pkg::vec_id_t             pop_id;
    logic                          empty;
    logic                          full;

    // Vector numbers cannot address more than MAX_SOURCES
    if (VEC_W < 1 || VEC_W > intc_pkg::MAX_SOURCES) begin : g_vec_w_check
        $error("VEC_W must be between 1 and MAX_SOURCES");
    end

    // Sync, edge detect, sticky pending
    int_capture #(.VEC_W(VEC_W)) u_capture (
        .clk          (clk),
        .rst          (rst),
        .int_in       (int_in),
        .mask         (mask),
        .claim_onehot (claim_onehot),
        .pending      (pending)
    );

    // Producer, one claim per cycle
    int_dispatch #(.VEC_W(VEC_W)) u_dispatch (
        .pending      (pending),
        .full         (full),
        .claim_onehot (claim_onehot),
        .push         (push),
        .push_id      (push_id)
    );

    // Claimed vectors waiting for the CPU
    vector_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .push    (push),
        .push_id (push_id),
        .pop     (pop),
        .pop_id  (pop_id),
        .empty   (empty),
        .full    (full),
        .count   ()   // Occupancy, not needed at this level
    );

    // Consumer, CPU side
    wb_intc_regs #(.VEC_W(VEC_W)) u_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .pending  (pending),
        .pop_id   (pop_id),
        .empty    (empty),
        .mask     (mask),
        .pop      (pop),
        .irq      (irq)
    );

endmodule

// File: verification/intc_asserts.sv
`timescale 1ns/1ps
/* Bound twice, once into the register block and once into the FIFO.
   WB_SIDE selects the bus and irq checks; unused ports are tied low at the bind */
module intc_asserts #(
    parameter bit WB_SIDE = 1'b1
) (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic push,
    input logic pop,
    input logic full,
    input logic empty,
    input logic irq
);

    if (WB_SIDE) begin : g_wb
        // Classic ack is a single pulse
        assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
            else $error("wb_ack held longer than one cycle");

        // Ack only in answer to a live request
        assert property (@(posedge clk) disable iff (rst)
            wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
            else $error("wb_ack without a preceding cyc and stb");

        // irq is not-empty, one cycle late
        assert property (@(posedge clk) disable iff (rst)
            !$past(rst) |-> (irq == !$past(empty)))
            else $error("irq does not follow not-empty by one cycle");
    end else begin : g_fifo
        // Pop only when a vector is queued
        assert property (@(posedge clk) disable iff (rst) !(pop && empty))
            else $error("pop while the FIFO is empty");

        assert property (@(posedge clk) disable iff (rst) !(push && full))
            else $error("push while the FIFO is full");
    end

endmodule

// Bus side
bind wb_intc_regs intc_asserts #(.WB_SIDE(1'b1)) u_regs_asserts (
    .clk    (clk),
    .rst    (rst),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .push   (1'b0),
    .pop    (1'b0),
    .full   (1'b0),
    .empty  (empty),
    .irq    (irq)
);

// Buffer side
bind vector_fifo intc_asserts #(.WB_SIDE(1'b0)) u_fifo_asserts (
    .clk    (clk),
    .rst    (rst),
    .wb_cyc (1'b0),
    .wb_stb (1'b0),
    .wb_ack (1'b0),
    .push   (push),
    .pop    (pop),
    .full   (full),
    .empty  (empty),
    .irq    (1'b0)
);

// File: verification/intc_tb.sv
`timescale 1ns/1ps
/* Runs with VEC_W 16 and FIFO_DEPTH 4. Each input change is given time to settle
   before the model is compared, so the model never has to track single cycles */
module intc_tb;

    localparam int VEC_W       = 16;
    localparam int FIFO_DEPTH  = 4;
    localparam int CLK_PERIOD  = 8;
    localparam int TEST_CYCLES = 1100;   // Worst-case sum over all phases
    localparam logic [VEC_W-1:0] ALL_ON = '1;

    logic               clk = 1'b0;
    logic               rst;
    logic [VEC_W-1:0]   int_in;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    intc_pkg::wb_addr_t wb_adr;
    intc_pkg::wb_data_t wb_dat_i;
    intc_pkg::wb_data_t wb_dat_o;
    logic               wb_ack;
    logic               irq;

    // Reference model
    logic [VEC_W-1:0] m_pend;    // Pending, not yet claimed
    logic [VEC_W-1:0] m_mask;
    logic [VEC_W-1:0] level;     // Last driven int_in
    int               m_fifo[$];

    intc_top #(.VEC_W(VEC_W), .FIFO_DEPTH(FIFO_DEPTH)) uut (
        .clk(clk), .rst(rst), .int_in(int_in),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack), .irq(irq)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic void stop_run(string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1);
    endfunction

    function automatic void mismatch(string msg);
        stop_run($sformatf("mismatch at %0t ns: %s", $time, msg));
    endfunction

    // Unused VECTOR bits between valid flag and id stay zero
    assert property (@(posedge clk) disable iff (rst)
        (wb_ack && !wb_we && wb_adr == intc_pkg::ADDR_VECTOR)
        |-> (wb_dat_o[30:intc_pkg::VEC_ID_W] == '0))
        else mismatch("VECTOR read with stray bits set");

    assert property (@(posedge clk) disable iff (rst)
        (wb_ack && !wb_we && wb_adr == intc_pkg::ADDR_STATUS)
        |-> (wb_dat_o[31:VEC_W] == '0))
        else mismatch("STATUS read not zero-extended");

    // FIFO takes the lowest pending source while it has room
    function automatic void refill();
        while (m_fifo.size() < FIFO_DEPTH && m_pend != '0) begin
            for (int i = 0; i < VEC_W; i++) begin
                if (m_pend[i]) begin
                    m_fifo.push_back(i);
                    m_pend[i] = 1'b0;
                    break;
                end
            end
        end
    endfunction

    task automatic settle(input int n);
        repeat (n) @(posedge clk);
    endtask

    // One classic cycle, data taken on the ack cycle
    task automatic wb_access(input logic write_en, input intc_pkg::wb_addr_t addr,
                             input intc_pkg::wb_data_t wdata,
                             output intc_pkg::wb_data_t rdata);
        int waited;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= write_en;
        wb_adr   <= addr;
        wb_dat_i <= wdata;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > 8) begin
                stop_run("no Wishbone acknowledge within 8 cycles");
            end
        end while (!wb_ack);
        rdata = wb_dat_o;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input intc_pkg::wb_addr_t addr, output intc_pkg::wb_data_t data);
        wb_access(1'b0, addr, '0, data);
    endtask

    task automatic wb_write(input intc_pkg::wb_addr_t addr, input intc_pkg::wb_data_t data);
        intc_pkg::wb_data_t unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    // Edges count only where enabled; a pending bit absorbs a new edge
    task automatic set_inputs(input logic [VEC_W-1:0] value);
        logic [VEC_W-1:0] rising;
        rising = value & ~level;
        @(posedge clk);
        int_in <= value;
        level = value;
        m_pend = m_pend | (rising & m_mask);
        refill();
        settle(10);
    endtask

    task automatic write_mask(input logic [VEC_W-1:0] value);
        wb_write(intc_pkg::ADDR_MASK, intc_pkg::wb_data_t'(value));
        m_mask = value;
        m_pend = m_pend & value;   // Disabled sources drop
        refill();
        settle(3);
    endtask

    task automatic check_vector();
        intc_pkg::wb_data_t exp;
        intc_pkg::wb_data_t got;
        exp = '0;
        if (m_fifo.size() > 0) begin
            exp[31] = 1'b1;
            exp[intc_pkg::VEC_ID_W-1:0] = intc_pkg::vec_id_t'(m_fifo.pop_front());
            refill();
        end
        wb_read(intc_pkg::ADDR_VECTOR, got);
        assert (got == exp) else mismatch($sformatf("VECTOR %h, expected %h", got, exp));
        settle(2);
    endtask

    task automatic check_status();
        intc_pkg::wb_data_t got;
        wb_read(intc_pkg::ADDR_STATUS, got);
        assert (got == intc_pkg::wb_data_t'(m_pend))
            else mismatch($sformatf("STATUS %h, expected %h", got, m_pend));
    endtask

    task automatic check_mask();
        intc_pkg::wb_data_t got;
        wb_read(intc_pkg::ADDR_MASK, got);
        assert (got == intc_pkg::wb_data_t'(m_mask))
            else mismatch($sformatf("MASK %h, expected %h", got, m_mask));
    endtask

    task automatic check_irq();
        settle(3);   // Covers a refill right after a pop
        assert (irq === (m_fifo.size() != 0))
            else mismatch($sformatf("irq %b with %0d queued", irq, m_fifo.size()));
    endtask

    task automatic drain();
        while (m_fifo.size() > 0) begin
            check_vector();
        end
        check_vector();   // Must come back not valid
        check_irq();
    endtask

    // Edge to irq is exactly 5 cycles with an empty FIFO
    task automatic single_source(input int s);
        logic [VEC_W-1:0] onehot;
        onehot = '0;
        onehot[s] = 1'b1;
        @(posedge clk);
        int_in <= onehot;
        level = onehot;
        repeat (5) begin
            @(posedge clk);
            assert (!irq) else mismatch($sformatf("irq early for source %0d", s));
        end
        @(posedge clk);
        assert (irq) else mismatch($sformatf("irq not high 5 cycles after source %0d", s));
        m_pend[s] = 1'b1;
        refill();
        set_inputs('0);
        check_vector();
        check_irq();
        check_vector();
    endtask

    // Watchdog
    initial begin
        #(TEST_CYCLES * CLK_PERIOD * 2);
        stop_run("timeout, the test did not finish in time");
    end

    initial begin
        logic [VEC_W-1:0] pick;
        logic [VEC_W-1:0] bit_m;
        int               s;
        int               nreads;
        void'($urandom(32'h226d91e7));
        rst      = 1'b1;
        int_in   = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;
        level    = '0;
        m_pend   = '0;
        m_mask   = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Reset state
        check_irq();
        check_status();
        check_mask();
        check_vector();

        // One source, all enabled
        write_mask(ALL_ON);
        check_mask();
        s = int'($urandom_range(0, VEC_W - 1));
        single_source(s);

        // Masked source stays silent, also when enabled while high
        s = int'($urandom_range(0, VEC_W - 1));
        bit_m = '0;
        bit_m[s] = 1'b1;
        write_mask(ALL_ON & ~bit_m);
        set_inputs(bit_m);
        check_status();
        check_vector();
        write_mask(ALL_ON);
        check_status();
        check_vector();
        set_inputs('0);

        // Source 7 waits behind a full FIFO, then loses its mask bit
        set_inputs(16'h008f);
        check_status();
        write_mask(ALL_ON & ~16'h0080);
        check_status();
        set_inputs('0);
        write_mask(ALL_ON);
        drain();

        // Same-cycle sources come out in ascending order
        pick = VEC_W'($urandom) | 16'h0101;
        set_inputs(pick);
        set_inputs('0);
        drain();

        // Eight at once against a 4-deep FIFO
        set_inputs(16'h5a5a);
        check_status();
        set_inputs('0);
        drain();

        // Source 9 pulses twice while still pending
        set_inputs(16'h000f);
        set_inputs('0);
        set_inputs(16'h0200);
        set_inputs('0);
        set_inputs(16'h0200);
        set_inputs('0);
        check_status();
        drain();

        // Random bursts with a few reads in between
        repeat (12) begin
            pick = VEC_W'($urandom);
            if (pick == '0) begin
                pick = 16'h0001;
            end
            set_inputs(pick);
            set_inputs('0);
            nreads = int'($urandom_range(0, 3));
            repeat (nreads) check_vector();
            check_status();
            check_irq();
        end
        drain();

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: verilog.f
logic/intc_pkg.sv
logic/int_capture.sv
logic/int_dispatch.sv
logic/vector_fifo.sv
logic/wb_intc_regs.sv
logic/intc_top.sv
verification/intc_asserts.sv
verification/intc_tb.sv

// File: Makefile
# Verilator build of the interrupt controller testbench

VERILATOR ?= verilator
TOP       := intc_tb
FILELIST  := verilog.f
FLAGS     := --binary --timing --assert -j 0
BUILD     := obj_dir

SIM     := $(BUILD)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD)
